// ==== all.f ====
design/modbus_pkg.sv
design/crc16_modbus.sv
design/uart_byte_tx.sv
design/bit_time_guard.sv
design/response_framer.sv
design/modbus_tx_response.sv
bench/tb_frame_checker.sv
bench/tb_modbus_tx.sv

// ==== bench/resp_golden.txt ====
# name func qty exc reg_base reg_step len(decimal) frame_bytes...
# all hex except len; reg_data = reg_base + reg_step * reg_addr
t03_q2 03 02 00 1234 1111 9 01 03 04 12 34 23 45 66 46
t04_q1 04 01 00 abcd 0000 7 01 04 02 ab cd 07 95
t03_q5 03 05 00 0000 0001 15 01 03 0a 00 00 00 01 00 02 00 03 00 04 bc 75
exc_03_02 03 02 02 0000 0000 5 01 83 02 c0 f1
exc_04_01 04 01 01 0000 0000 5 01 84 01 82 c0

// ==== bench/tb_frame_checker.sv ====
module tb_frame_checker (
    input  logic clk_in,
    input  logic rst_n_in,
    input  logic rs485_tx,
    input  logic rs485_tx_en,
    input  logic response_done,
    output int   tests_passed,
    output int   tests_failed,
    output int   line_errors
);
    import modbus_pkg::*;

    string cur_name;
    byte_t exp_bytes [0:31];
    byte_t got_bytes [0:31];
    int    exp_len;
    int    got_len;
    logic  armed;
    logic  test_bad;
    logic  first_start;     // lead guard still to be checked

    logic  rx_busy;
    int    bit_idx;
    int    cyc;             // cycles since the start edge
    byte_t shreg;
    logic  prev_tx;
    logic  prev_en;
    int    en_cycles;

    initial
    begin
        tests_passed = 0;
        tests_failed = 0;
        line_errors  = 0;
        cur_name     = "none";
        exp_len      = 0;
        got_len      = 0;
        armed        = 1'b0;
        test_bad     = 1'b0;
        first_start  = 1'b0;
        rx_busy      = 1'b0;
        bit_idx      = 0;
        cyc          = 0;
        shreg        = '0;
        prev_tx      = 1'b1;
        prev_en      = 1'b0;
        en_cycles    = 0;
    end

    task set_expected(input int idx, input byte_t value);
        exp_bytes[idx] = value;
    endtask

    task expect_frame(input string name, input int len);
        cur_name    = name;
        exp_len     = len;
        got_len     = 0;
        test_bad    = 1'b0;
        first_start = 1'b1;
        armed       = 1'b1;
    endtask

    task line_error(input string what);
        $display("%s (test %s)", what, cur_name);
        line_errors++;
        test_bad = 1'b1;
    endtask

    task automatic finish_frame();
        int k;
        if (got_len != exp_len)
        begin
            $display("FAIL %s frame length: expected %0d, actual %0d", cur_name, exp_len, got_len);
            test_bad = 1'b1;
        end
        for (k = 0; k < exp_len && k < got_len; k++)
        begin
            if (got_bytes[k] !== exp_bytes[k])
            begin
                $display("FAIL %s byte %0d: expected %02h, actual %02h",
                         cur_name, k, exp_bytes[k], got_bytes[k]);
                test_bad = 1'b1;
            end
        end
        if (test_bad)
        begin
            tests_failed++;
            $display("test %s failed", cur_name);
        end
        else
        begin
            tests_passed++;
            $display("test %s passed, %0d bytes", cur_name, got_len);
        end
        armed = 1'b0;
    endtask

    task take_byte();
        if (!armed)
            line_error("byte received with no test running");
        else
        begin
            if (got_len < 32)
                got_bytes[got_len] = shreg;
            got_len++;
        end
    endtask

    always @(posedge clk_in)
    begin
        if (rst_n_in)
        begin
            if (!rs485_tx_en && rs485_tx !== 1'b1)
                line_error("line is low while the driver is off");
            if (prev_en && !rs485_tx_en && !response_done)
                line_error("driver released without response_done");
            if (response_done && rs485_tx_en)
                line_error("response_done came while the driver stayed on");
            if (rs485_tx_en && !prev_en)
            begin
                en_cycles = 0;
                if (!armed)
                    line_error("driver enabled with no test running");
            end
            else if (rs485_tx_en)
                en_cycles++;

            if (rx_busy)
            begin
                cyc++;
                if (cyc == BAUD_DIV / 2 + bit_idx * BAUD_DIV)   // middle of the bit
                begin
                    case (bit_idx)
                        0:
                            if (rs485_tx)
                                line_error("start bit did not stay low");
                        9:
                        begin
                            if (!rs485_tx)
                                line_error("stop bit missing");
                            take_byte();
                            rx_busy = 1'b0;
                        end
                        default:
                            shreg = {rs485_tx, shreg[7:1]};  // lsb first
                    endcase
                    bit_idx++;
                end
            end
            else if (rs485_tx_en && prev_tx && !rs485_tx)
            begin
                if (first_start && en_cycles < GUARD_BITS * BAUD_DIV)
                    line_error("first start bit came before the lead guard ran out");
                first_start = 1'b0;
                rx_busy     = 1'b1;
                cyc         = 0;
                bit_idx     = 0;
            end

            if (response_done)
            begin
                if (!armed)
                    line_error("response_done with no frame in flight");
                else
                    finish_frame();
            end
            prev_tx = rs485_tx;
            prev_en = rs485_tx_en;
        end
    end

endmodule

// ==== bench/tb_modbus_tx.sv ====
module tb_modbus_tx;
    import modbus_pkg::*;

    localparam int RETRIGGER_AT = 12 * BAUD_DIV;    // inside the address byte
    localparam int IDLE_GAP     = 2000;

    logic      clk_in;
    logic      rst_n_in;
    logic      tx_start;
    resp_req_t req;
    reg_word_t reg_data;
    reg_addr_t reg_addr;
    logic      rs485_tx;
    logic      rs485_tx_en;
    logic      response_done;

    reg_word_t reg_base;
    reg_word_t reg_step;
    int        tests_run;
    logic      timed_out;
    logic      file_ok;
    int        tests_passed;
    int        tests_failed;
    int        line_errors;

    // register model
    assign reg_data = reg_base + reg_step * reg_word_t'(reg_addr);

    modbus_tx_response i_dut (
        .clk_in        (clk_in),
        .rst_n_in      (rst_n_in),
        .tx_start      (tx_start),
        .req           (req),
        .reg_data      (reg_data),
        .reg_addr      (reg_addr),
        .rs485_tx      (rs485_tx),
        .rs485_tx_en   (rs485_tx_en),
        .response_done (response_done)
    );

    tb_frame_checker i_chk (
        .clk_in        (clk_in),
        .rst_n_in      (rst_n_in),
        .rs485_tx      (rs485_tx),
        .rs485_tx_en   (rs485_tx_en),
        .response_done (response_done),
        .tests_passed  (tests_passed),
        .tests_failed  (tests_failed),
        .line_errors   (line_errors)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    task automatic send_request(input string name, input int len);
        int cycles;
        int limit;
        limit = (len + 4) * 10 * BAUD_DIV;
        i_chk.expect_frame(name, len);
        @(posedge clk_in);
        #2;
        tx_start = 1'b1;
        @(posedge clk_in);
        #2;
        tx_start = 1'b0;
        cycles   = 0;
        while (!response_done && cycles < limit)
        begin
            @(posedge clk_in);
            #2;
            cycles++;
            tx_start = (cycles == RETRIGGER_AT);    // stray start, must be ignored
        end
        tx_start = 1'b0;
        if (!response_done)
        begin
            $display("timeout: test %s saw no response_done within %0d cycles", name, limit);
            timed_out = 1'b1;
        end
        else
        begin
            repeat (IDLE_GAP) @(posedge clk_in);    // a second done here is an error
            #2;
        end
    endtask

    task automatic run_golden_file();
        int               fd;
        int               code;
        int               len_v;
        int               k;
        logic [7:0]       func_v;
        logic [7:0]       qty_v;
        logic [7:0]       exc_v;
        logic [7:0]       byte_v;
        logic [15:0]      base_v;
        logic [15:0]      step_v;
        string            tname;
        logic [8*256-1:0] rest;
        fd = $fopen("bench/resp_golden.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open bench/resp_golden.txt");
            file_ok = 1'b0;
        end
        else
        begin
            while (file_ok && !timed_out && $fscanf(fd, "%s", tname) == 1)
            begin
                if (tname[0] == "#")
                    code = $fgets(rest, fd);
                else
                begin
                    code = $fscanf(fd, "%h %h %h %h %h %d",
                                   func_v, qty_v, exc_v, base_v, step_v, len_v);
                    if (code != 6 || len_v < 1 || len_v > 32)
                    begin
                        $display("malformed golden line for test %s", tname);
                        file_ok = 1'b0;
                    end
                    for (k = 0; file_ok && k < len_v; k++)
                    begin
                        code = $fscanf(fd, "%h", byte_v);
                        if (code != 1)
                        begin
                            $display("golden line for test %s is missing frame bytes", tname);
                            file_ok = 1'b0;
                        end
                        i_chk.set_expected(k, byte_v);
                    end
                    if (file_ok)
                    begin
                        req      = resp_req_t'({func_v, qty_v, exc_v});
                        reg_base = base_v;
                        reg_step = step_v;
                        tests_run++;
                        send_request(tname, len_v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial
    begin
        rst_n_in  = 1'b0;
        tx_start  = 1'b0;
        req       = '0;
        reg_base  = '0;
        reg_step  = '0;
        tests_run = 0;
        timed_out = 1'b0;
        file_ok   = 1'b1;
        repeat (3) @(posedge clk_in);
        #2;
        rst_n_in = 1'b1;
        repeat (5) @(posedge clk_in);
        #2;
        run_golden_file();
        $display("tests run %0d: %0d passed, %0d failed, %0d line errors",
                 tests_run, tests_passed, tests_failed, line_errors);
        if (file_ok && !timed_out && tests_run > 0 && tests_passed == tests_run
            && tests_failed == 0 && line_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== design/bit_time_guard.sv ====
module bit_time_guard (
    input  logic clk_in,
    input  logic rst_n_in,
    input  logic guard_start,
    output logic guard_done
);
    import modbus_pkg::*;

    logic                          running;
    logic [$clog2(BAUD_DIV)-1:0]   cyc_cnt;
    logic [$clog2(GUARD_BITS)-1:0] bit_cnt;

    // cyc_cnt preloads to 1 so guard_done lands exactly GUARD_BITS bit times on
    always_ff @(posedge clk_in or negedge rst_n_in)
    begin
        if (!rst_n_in)
        begin
            running    <= 1'b0;
            cyc_cnt    <= '0;
            bit_cnt    <= '0;
            guard_done <= 1'b0;
        end
        else
        begin
            guard_done <= 1'b0;
            if (guard_start)
            begin
                running <= 1'b1;
                cyc_cnt <= 1;
                bit_cnt <= '0;
            end
            else if (running)
            begin
                if (int'(cyc_cnt) == BAUD_DIV - 1)
                begin
                    cyc_cnt <= '0;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (int'(bit_cnt) == GUARD_BITS - 1)
                    begin
                        running    <= 1'b0;
                        guard_done <= 1'b1;
                    end
                end
                else
                    cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    // no restart in the middle of a guard
    a_no_restart: assert property (
        @(posedge clk_in) disable iff (!rst_n_in) guard_start |-> !running);

endmodule

// ==== design/crc16_modbus.sv ====
module crc16_modbus (
    input  logic                  clk_in,
    input  logic                  rst_n_in,
    input  logic                  crc_clear,
    input  logic                  crc_feed,
    input  modbus_pkg::byte_t     crc_byte,
    output modbus_pkg::reg_word_t crc_value
);
    import modbus_pkg::*;

    reg_word_t  crc_reg;
    reg_word_t  mixed;
    logic [2:0] step_cnt;   // shift steps still owed

    function automatic reg_word_t crc_step(input reg_word_t value);
        reg_word_t shifted;
        shifted = value >> 1;
        return value[0] ? (shifted ^ CRC_POLY) : shifted;
    endfunction

    assign mixed = {crc_reg[15:8], crc_reg[7:0] ^ crc_byte};

    // first step happens in the feed cycle, seven follow
    always_ff @(posedge clk_in or negedge rst_n_in)
    begin
        if (!rst_n_in)
        begin
            crc_reg  <= CRC_INIT;
            step_cnt <= 3'd0;
        end
        else if (crc_clear)
        begin
            crc_reg  <= CRC_INIT;
            step_cnt <= 3'd0;
        end
        else if (crc_feed)
        begin
            crc_reg  <= crc_step(mixed);
            step_cnt <= 3'd7;
        end
        else if (step_cnt != 3'd0)
        begin
            crc_reg  <= crc_step(crc_reg);
            step_cnt <= step_cnt - 3'd1;
        end
    end

    assign crc_value = crc_reg;

    a_no_feed_while_busy: assert property (
        @(posedge clk_in) disable iff (!rst_n_in) crc_feed |-> step_cnt == 3'd0);

endmodule

// ==== design/modbus_pkg.sv ====
package modbus_pkg;

    localparam int CLK_FREQ   = 50_000_000;
    localparam int BAUD_RATE  = 115_200;
    localparam int BAUD_DIV   = CLK_FREQ / BAUD_RATE;   // clocks per bit
    localparam int GUARD_BITS = 10;                     // line turnaround, in bit times
    localparam int MAX_QTY    = 125;

    localparam logic [7:0]  SLAVE_ADDR = 8'h01;
    localparam logic [15:0] CRC_INIT   = 16'hFFFF;
    localparam logic [15:0] CRC_POLY   = 16'hA001;      // 0x8005 reflected
    localparam logic [7:0]  EXC_FLAG   = 8'h80;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] reg_word_t;
    typedef logic [7:0]  reg_addr_t;

    typedef enum logic [7:0] {
        FUNC_READ_HOLDING = 8'h03,
        FUNC_READ_INPUT   = 8'h04
    } func_code_e;

    typedef enum logic [3:0] {
        IDLE,
        LEAD_GUARD,
        SEND_ADDR,
        SEND_FUNC,
        SEND_COUNT,
        SEND_EXC,
        SEND_DATA_HI,
        SEND_DATA_LO,
        SEND_CRC_LO,
        SEND_CRC_HI,
        TRAIL_GUARD
    } frame_state_e;

    // one response request, held by the caller for the whole frame
    typedef struct packed {
        func_code_e func;
        byte_t      quantity;   // registers to return
        byte_t      exception;  // nonzero selects the exception reply
    } resp_req_t;

endpackage

// ==== design/modbus_tx_response.sv ====
module modbus_tx_response (
    input  logic                  clk_in,
    input  logic                  rst_n_in,
    input  logic                  tx_start,
    input  modbus_pkg::resp_req_t req,
    input  modbus_pkg::reg_word_t reg_data,
    output modbus_pkg::reg_addr_t reg_addr,
    output logic                  rs485_tx,
    output logic                  rs485_tx_en,
    output logic                  response_done
);
    import modbus_pkg::*;

    logic      byte_start;
    logic      byte_done;
    byte_t     tx_byte;
    logic      crc_clear;
    logic      crc_feed;
    byte_t     crc_byte;
    reg_word_t crc_value;
    logic      guard_start;
    logic      guard_done;

    response_framer i_framer (
        .clk_in        (clk_in),
        .rst_n_in      (rst_n_in),
        .tx_start      (tx_start),
        .req           (req),
        .reg_data      (reg_data),
        .reg_addr      (reg_addr),
        .byte_start    (byte_start),
        .tx_byte       (tx_byte),
        .byte_done     (byte_done),
        .crc_clear     (crc_clear),
        .crc_feed      (crc_feed),
        .crc_byte      (crc_byte),
        .crc_value     (crc_value),
        .guard_start   (guard_start),
        .guard_done    (guard_done),
        .rs485_tx_en   (rs485_tx_en),
        .response_done (response_done)
    );

    crc16_modbus i_crc (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .crc_clear (crc_clear),
        .crc_feed  (crc_feed),
        .crc_byte  (crc_byte),
        .crc_value (crc_value)
    );

    uart_byte_tx i_uart (
        .clk_in     (clk_in),
        .rst_n_in   (rst_n_in),
        .byte_start (byte_start),
        .tx_byte    (tx_byte),
        .byte_done  (byte_done),
        .rs485_tx   (rs485_tx)
    );

    bit_time_guard i_guard (
        .clk_in      (clk_in),
        .rst_n_in    (rst_n_in),
        .guard_start (guard_start),
        .guard_done  (guard_done)
    );

endmodule

// ==== design/response_framer.sv ====
module response_framer (
    input  logic                  clk_in,
    input  logic                  rst_n_in,
    input  logic                  tx_start,
    input  modbus_pkg::resp_req_t req,
    input  modbus_pkg::reg_word_t reg_data,
    output modbus_pkg::reg_addr_t reg_addr,
    output logic                  byte_start,
    output modbus_pkg::byte_t     tx_byte,
    input  logic                  byte_done,
    output logic                  crc_clear,
    output logic                  crc_feed,
    output modbus_pkg::byte_t     crc_byte,
    input  modbus_pkg::reg_word_t crc_value,
    output logic                  guard_start,
    input  logic                  guard_done,
    output logic                  rs485_tx_en,
    output logic                  response_done
);
    import modbus_pkg::*;

    frame_state_e state;
    frame_state_e after_send;
    byte_t        next_byte;
    byte_t        data_lo;
    logic         launched;     // current byte handed to the uart
    logic         launch;
    logic         is_exc;

    assign is_exc = req.exception != 8'h00;

    always_comb
    begin
        next_byte  = '0;
        after_send = state;
        unique case (state)
            SEND_ADDR:
            begin
                next_byte  = SLAVE_ADDR;
                after_send = SEND_FUNC;
            end
            SEND_FUNC:
            begin
                next_byte  = is_exc ? (byte_t'(req.func) | EXC_FLAG) : byte_t'(req.func);
                after_send = is_exc ? SEND_EXC : SEND_COUNT;
            end
            SEND_COUNT:
            begin
                next_byte  = req.quantity << 1;   // two bytes per register
                after_send = (req.quantity == 8'h00) ? SEND_CRC_LO : SEND_DATA_HI;
            end
            SEND_EXC:
            begin
                next_byte  = req.exception;
                after_send = SEND_CRC_LO;
            end
            SEND_DATA_HI:
            begin
                next_byte  = reg_data[15:8];
                after_send = SEND_DATA_LO;
            end
            SEND_DATA_LO:
            begin
                next_byte  = data_lo;
                after_send = (reg_addr == req.quantity) ? SEND_CRC_LO : SEND_DATA_HI;
            end
            SEND_CRC_LO:
            begin
                next_byte  = crc_value[7:0];
                after_send = SEND_CRC_HI;
            end
            SEND_CRC_HI:
            begin
                next_byte  = crc_value[15:8];
                after_send = TRAIL_GUARD;
            end
            default:
                next_byte = '0;
        endcase
    end

    assign launch = !launched && state inside {[SEND_ADDR:SEND_CRC_HI]};

    always_ff @(posedge clk_in or negedge rst_n_in)
    begin
        if (!rst_n_in)
        begin
            state         <= IDLE;
            launched      <= 1'b0;
            reg_addr      <= '0;
            byte_start    <= 1'b0;
            crc_clear     <= 1'b0;
            crc_feed      <= 1'b0;
            guard_start   <= 1'b0;
            rs485_tx_en   <= 1'b0;
            response_done <= 1'b0;
        end
        else
        begin
            byte_start    <= launch;
            crc_feed      <= launch && !(state inside {SEND_CRC_LO, SEND_CRC_HI});
            crc_clear     <= 1'b0;
            guard_start   <= 1'b0;
            response_done <= 1'b0;
            if (launch)
                launched <= 1'b1;
            if (launch && state == SEND_DATA_HI)
                reg_addr <= reg_addr + 1'b1;   // doubles as the word count
            case (state)
                IDLE:
                    if (tx_start)
                    begin
                        state       <= LEAD_GUARD;
                        rs485_tx_en <= 1'b1;
                        guard_start <= 1'b1;
                        crc_clear   <= 1'b1;
                        reg_addr    <= '0;
                    end
                LEAD_GUARD:
                    if (guard_done)
                        state <= SEND_ADDR;
                TRAIL_GUARD:
                    if (guard_done)
                    begin
                        state         <= IDLE;
                        rs485_tx_en   <= 1'b0;
                        response_done <= 1'b1;
                    end
                default:
                    if (launched && byte_done)
                    begin
                        launched    <= 1'b0;
                        state       <= after_send;
                        guard_start <= after_send == TRAIL_GUARD;
                    end
            endcase
        end
    end

    // outgoing byte and low half of the word, loaded as each byte goes out
    always_ff @(posedge clk_in)
    begin
        if (launch)
            tx_byte <= next_byte;
        if (launch && state == SEND_DATA_HI)
            data_lo <= reg_data[7:0];
    end

    assign crc_byte = tx_byte;

    a_req_valid: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        (state == IDLE && tx_start && !is_exc)
            |-> (req.func inside {FUNC_READ_HOLDING, FUNC_READ_INPUT}
                 && req.quantity <= MAX_QTY));

endmodule

// ==== design/uart_byte_tx.sv ====
module uart_byte_tx (
    input  logic              clk_in,
    input  logic              rst_n_in,
    input  logic              byte_start,
    input  modbus_pkg::byte_t tx_byte,
    output logic              byte_done,
    output logic              rs485_tx
);
    import modbus_pkg::*;

    logic                        busy;
    logic [$clog2(BAUD_DIV)-1:0] baud_cnt;
    logic [3:0]                  bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic [8:0]                  tx_shift;  // stop bit above the data
    logic                        bit_end;

    assign bit_end = int'(baud_cnt) == BAUD_DIV - 1;

    always_ff @(posedge clk_in or negedge rst_n_in)
    begin
        if (!rst_n_in)
        begin
            busy      <= 1'b0;
            baud_cnt  <= '0;
            bit_cnt   <= 4'd0;
            byte_done <= 1'b0;
            rs485_tx  <= 1'b1;
        end
        else
        begin
            byte_done <= 1'b0;
            if (!busy)
            begin
                baud_cnt <= '0;
                bit_cnt  <= 4'd0;
                if (byte_start)
                begin
                    busy     <= 1'b1;
                    rs485_tx <= 1'b0;   // start bit
                end
            end
            else if (bit_end)
            begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9)
                begin
                    busy      <= 1'b0;
                    byte_done <= 1'b1;
                end
                else
                begin
                    bit_cnt  <= bit_cnt + 4'd1;
                    rs485_tx <= tx_shift[0];
                end
            end
            else
            begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (!busy && byte_start)
            tx_shift <= {1'b1, tx_byte};
        else if (busy && bit_end)
            tx_shift <= {1'b1, tx_shift[8:1]};  // lsb first
    end

    a_start_when_idle: assert property (
        @(posedge clk_in) disable iff (!rst_n_in) byte_start |-> !busy);

endmodule
